//--- Makefile
# Verilator build for the divide unit testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timing --timescale $(TIMESCALE)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- common/div_pkg.sv
`default_nettype none

package div_pkg;

    // operand and result width
    localparam int unsigned xlen = 32;

    // partial remainder carries one extra bit for the compare
    localparam int unsigned rem_w = xlen + 1;

    // one restoring step per quotient bit
    localparam int unsigned num_cells = xlen;

    // producer + cells + consumer
    localparam int unsigned div_latency = num_cells + 2;

    // request as seen at the unit boundary
    typedef struct packed {
        logic [xlen-1:0] dividend;
        logic [xlen-1:0] divisor;
        logic            signed_op;  // div/rem vs divu/remu
        logic            rem_sel;    // 1 selects the remainder
    } div_req_t;

    // side info that rides along with each request
    typedef struct packed {
        logic neg_quot;  // quotient must be negated
        logic neg_rem;   // remainder must be negated
        logic div_zero;  // divisor was zero
        logic rem_sel;   // return the remainder
    } div_tag_t;

    // state handed from one divider cell to the next
    typedef struct packed {
        logic [rem_w-1:0] rem;   // partial remainder
        logic [xlen-1:0]  quot;  // quotient bits so far
        logic [xlen-1:0]  dvd;   // dividend bits not yet consumed
        logic [xlen-1:0]  dvs;   // divisor magnitude
        div_tag_t         tag;
        logic             valid;
    } div_stage_t;

    // result word toward the core
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
    } div_result_t;

endpackage

`default_nettype wire

//--- divider/div_operand_prep.sv
`default_nettype none

module div_operand_prep import div_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       in_valid,
    input  div_req_t   req,
    output div_stage_t stage_in
);

    logic            dvd_neg;
    logic            dvs_neg;
    logic [xlen-1:0] dvd_mag;
    logic [xlen-1:0] dvs_mag;
    logic            dvs_zero;
    div_stage_t      stage_d;

    // operand signs only count for signed ops
    assign dvd_neg = req.signed_op & req.dividend[xlen-1];
    assign dvs_neg = req.signed_op & req.divisor[xlen-1];

    assign dvd_mag  = dvd_neg ? (~req.dividend + 1'b1) : req.dividend;
    assign dvs_mag  = dvs_neg ? (~req.divisor + 1'b1) : req.divisor;
    assign dvs_zero = (req.divisor == '0);

    always_comb begin
        stage_d              = '0;
        stage_d.rem          = '0;          // nothing shifted in yet
        stage_d.quot         = '0;
        stage_d.dvd          = dvd_mag;
        stage_d.dvs          = dvs_mag;
        // x/0 keeps the quotient positive so the all-ones result survives
        stage_d.tag.neg_quot = (dvd_neg ^ dvs_neg) & ~dvs_zero;
        stage_d.tag.neg_rem  = dvd_neg;     // remainder follows the dividend
        stage_d.tag.div_zero = dvs_zero;
        stage_d.tag.rem_sel  = req.rem_sel;
        stage_d.valid        = in_valid;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stage_in <= '0;
        end else begin
            stage_in.valid <= in_valid;
            if (in_valid) begin
                stage_in <= stage_d;
            end
        end
    end

endmodule

`default_nettype wire

//--- divider/div_pipeline.sv
`default_nettype none

module div_pipeline import div_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  div_stage_t stage_in,
    output div_stage_t stage_out
);

    // chain[k] feeds cell k, chain[num_cells] is the final stage
    div_stage_t chain [0:num_cells];

    assign chain[0] = stage_in;

    // one cell per quotient bit, msb first
    // each cell holds one request, so order is kept by construction
    for (genvar k = 0; k < num_cells; k++) begin : g_cell
        divider_cell u_cell (
            .clk     (clk),
            .rstn    (rstn),
            .stage_d (chain[k]),
            .stage_q (chain[k+1])
        );
    end

    // quotient and remainder are complete after the last step
    assign stage_out = chain[num_cells];

endmodule

`default_nettype wire

//--- divider/divider_cell.sv
`default_nettype none

module divider_cell import div_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  div_stage_t stage_d,
    output div_stage_t stage_q
);

    logic [rem_w-1:0] shifted;
    logic [rem_w-1:0] dvs_ext;
    logic             fits;
    div_stage_t       stage_n;

    // bring down the next dividend bit
    assign shifted = {stage_d.rem[rem_w-2:0], stage_d.dvd[xlen-1]};
    assign dvs_ext = {1'b0, stage_d.dvs};
    assign fits    = (shifted >= dvs_ext);

    always_comb begin
        stage_n       = stage_d;
        stage_n.rem   = fits ? (shifted - dvs_ext) : shifted;  // restore on miss
        stage_n.quot  = {stage_d.quot[xlen-2:0], fits};
        stage_n.dvd   = {stage_d.dvd[xlen-2:0], 1'b0};
    end

    // payload only moves with a live request
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stage_q <= '0;
        end else begin
            stage_q.valid <= stage_d.valid;
            if (stage_d.valid) begin
                stage_q <= stage_n;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/div_result_fix.sv
`default_nettype none

module div_result_fix import div_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  div_stage_t  stage_out,
    output div_result_t res
);

    logic [xlen-1:0] quot_mag;
    logic [xlen-1:0] rem_mag;
    logic [xlen-1:0] quot_fix;
    logic [xlen-1:0] rem_fix;
    logic [xlen-1:0] data_n;

    assign quot_mag = stage_out.quot;
    assign rem_mag  = stage_out.rem[xlen-1:0];  // top bit is zero after the last step

    always_comb begin
        quot_fix = stage_out.tag.neg_quot ? (~quot_mag + 1'b1) : quot_mag;
        if (stage_out.tag.div_zero) begin
            quot_fix = '1;  // riscv x/0
        end
        // remainder of x/0 is |x|, so negating it returns the dividend
        rem_fix = stage_out.tag.neg_rem ? (~rem_mag + 1'b1) : rem_mag;
        data_n  = stage_out.tag.rem_sel ? rem_fix : quot_fix;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res <= '0;
        end else begin
            res.valid <= stage_out.valid;
            if (stage_out.valid) begin
                res.data <= data_n;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/div_top.sv
`default_nettype none

module div_top import div_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        in_valid,
    input  div_req_t    req,
    output div_result_t res
);

    div_stage_t stage_in;   // producer to first cell
    div_stage_t stage_out;  // last cell to consumer

    div_operand_prep u_prep (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .req      (req),
        .stage_in (stage_in)
    );

    div_pipeline u_pipe (
        .clk       (clk),
        .rstn      (rstn),
        .stage_in  (stage_in),
        .stage_out (stage_out)
    );

    div_result_fix u_fix (
        .clk       (clk),
        .rstn      (rstn),
        .stage_out (stage_out),
        .res       (res)
    );

endmodule

`default_nettype wire

//--- project.f
common/div_pkg.sv
divider/div_operand_prep.sv
divider/divider_cell.sv
divider/div_pipeline.sv
logic/div_result_fix.sv
logic/div_top.sv
sim/div_chk.sv
sim/div_tb.sv

//--- sim/div_chk.sv
`default_nettype none

module div_chk import div_pkg::*; (
    input logic        clk,
    input logic        rstn,
    input logic        in_valid,
    input div_result_t res
);

    timeunit 1ns;
    timeprecision 1ps;

    // flops are held clear while reset is asserted
    a_reset_quiet: assert property (
        @(posedge clk) !rstn |-> !res.valid
    ) else $error("res.valid high while rstn is low");

    // fixed latency, no stalls
    a_latency: assert property (
        @(posedge clk) disable iff (!rstn)
        in_valid |-> ##div_latency res.valid
    ) else $error("in_valid not followed by res.valid after div_latency cycles");

    // nothing comes out that was not sent in
    a_no_orphan: assert property (
        @(posedge clk) disable iff (!rstn)
        res.valid |-> $past(in_valid, div_latency)
    ) else $error("res.valid without a matching in_valid");

endmodule

bind div_top div_chk i_chk (
    .clk      (clk),
    .rstn     (rstn),
    .in_valid (in_valid),
    .res      (res)
);

`default_nettype wire

//--- sim/div_tb.sv
`default_nettype none

module div_tb import div_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;
    localparam int idle_cycles  = 5;   // res must stay quiet here
    localparam int drain_cycles = 5;
    localparam int num_dir      = 28;
    localparam int num_rand     = 200;
    localparam int num_vec      = num_dir + num_rand;
    localparam int wd_cycles    = reset_cycles + idle_cycles + num_vec + div_latency + 20
                                  + drain_cycles;

    localparam logic [xlen-1:0] min_neg = {1'b1, {(xlen-1){1'b0}}};

    typedef struct packed {
        div_req_t        req;
        logic [xlen-1:0] exp;
    } vec_t;

    typedef struct packed {
        logic [31:0]     due;   // cycle index of the result
        logic [xlen-1:0] data;
    } exp_t;

    logic        clk;
    logic        rstn;
    logic        in_valid;
    div_req_t    req;
    div_result_t res;

    int unsigned cycle = 0;
    logic [31:0] lfsr = 32'h2020f890;
    logic        expect_valid;
    exp_t        exp_q [$];

    // dividend, divisor, signed_op, rem_sel, expected
    vec_t dir_tab [num_dir] = '{
        '{'{32'h0000_0064, 32'h0000_0007, 1'b0, 1'b0}, 32'h0000_000e},
        '{'{32'h0000_0064, 32'h0000_0007, 1'b0, 1'b1}, 32'h0000_0002},
        '{'{32'h0000_0005, 32'h0000_0009, 1'b0, 1'b0}, 32'h0000_0000},
        '{'{32'h0000_0005, 32'h0000_0009, 1'b0, 1'b1}, 32'h0000_0005},
        '{'{32'hffff_ffff, 32'h0000_0003, 1'b0, 1'b0}, 32'h5555_5555},
        '{'{32'hffff_ffff, 32'h0000_0003, 1'b0, 1'b1}, 32'h0000_0000},
        '{'{32'hffff_ffff, 32'h0000_0001, 1'b0, 1'b0}, 32'hffff_ffff},
        '{'{32'hffff_ffff, 32'h8000_0000, 1'b0, 1'b0}, 32'h0000_0001},
        '{'{32'hffff_ffff, 32'h8000_0000, 1'b0, 1'b1}, 32'h7fff_ffff},
        '{'{32'h0000_0007, 32'h0000_0002, 1'b1, 1'b0}, 32'h0000_0003},
        '{'{32'h0000_0007, 32'h0000_0002, 1'b1, 1'b1}, 32'h0000_0001},
        '{'{32'hffff_fff9, 32'h0000_0002, 1'b1, 1'b0}, 32'hffff_fffd},
        '{'{32'hffff_fff9, 32'h0000_0002, 1'b1, 1'b1}, 32'hffff_ffff},
        '{'{32'h0000_0007, 32'hffff_fffe, 1'b1, 1'b0}, 32'hffff_fffd},
        '{'{32'h0000_0007, 32'hffff_fffe, 1'b1, 1'b1}, 32'h0000_0001},
        '{'{32'hffff_fff9, 32'hffff_fffe, 1'b1, 1'b0}, 32'h0000_0003},
        '{'{32'hffff_fff9, 32'hffff_fffe, 1'b1, 1'b1}, 32'hffff_ffff},
        '{'{32'h0000_04d2, 32'h0000_0000, 1'b0, 1'b0}, 32'hffff_ffff},
        '{'{32'h0000_04d2, 32'h0000_0000, 1'b0, 1'b1}, 32'h0000_04d2},
        '{'{32'hffff_fffb, 32'h0000_0000, 1'b1, 1'b0}, 32'hffff_ffff},
        '{'{32'hffff_fffb, 32'h0000_0000, 1'b1, 1'b1}, 32'hffff_fffb},
        '{'{32'h0000_002a, 32'h0000_0000, 1'b1, 1'b0}, 32'hffff_ffff},
        '{'{32'h0000_002a, 32'h0000_0000, 1'b1, 1'b1}, 32'h0000_002a},
        '{'{32'h8000_0000, 32'h0000_0000, 1'b0, 1'b1}, 32'h8000_0000},
        '{'{32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b0}, 32'h8000_0000},
        '{'{32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1}, 32'h0000_0000},
        '{'{32'h8000_0000, 32'h0000_0002, 1'b1, 1'b0}, 32'hc000_0000},
        '{'{32'h8000_0000, 32'h0000_0002, 1'b1, 1'b1}, 32'h0000_0000}
    };

    div_top i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .req      (req),
        .res      (res)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // riscv div/divu/rem/remu
    function automatic logic [xlen-1:0] ref_div(input div_req_t r);
        logic signed [xlen-1:0] sa;
        logic signed [xlen-1:0] sb;
        logic [xlen-1:0]        q;
        logic [xlen-1:0]        rm;
        sa = r.dividend;
        sb = r.divisor;
        if (r.divisor == '0) begin
            q  = '1;
            rm = r.dividend;
        end else if (!r.signed_op) begin
            q  = r.dividend / r.divisor;
            rm = r.dividend % r.divisor;
        end else if (r.dividend == min_neg && r.divisor == '1) begin
            q  = r.dividend;   // overflow case
            rm = '0;
        end else begin
            q  = sa / sb;      // truncates toward zero
            rm = sa % sb;
        end
        return r.rem_sel ? rm : q;
    endfunction

    task automatic check_table();
        for (int i = 0; i < num_dir; i++) begin
            if (ref_div(dir_tab[i].req) !== dir_tab[i].exp) begin
                $display("directed entry %0d disagrees with the reference model", i);
                $display("Testbench failed");
                $fatal(1, "inconsistent directed table");
            end
        end
    endtask

    task automatic send_req(input div_req_t r, input logic [xlen-1:0] exp);
        exp_t e;
        e.due  = cycle + div_latency;
        e.data = exp;
        in_valid <= 1'b1;
        req      <= r;
        exp_q.push_back(e);
    endtask

    task automatic check_valid(input div_result_t got, input logic exp_v);
        if (got.valid !== exp_v) begin
            $display("MISMATCH at %0t: res.valid is %b, expected %b", $time, got.valid, exp_v);
            $display("Testbench failed");
            $fatal(1, "valid strobe check");
        end
    endtask

    task automatic check_data(input div_result_t got, input logic [xlen-1:0] exp);
        if (got.data !== exp) begin
            $display("MISMATCH at %0t: res.data is %h, expected %h", $time, got.data, exp);
            $display("Testbench failed");
            $fatal(1, "data check");
        end
    endtask

    // outputs settle between edges
    always @(negedge clk) begin
        expect_valid = (exp_q.size() != 0) && (exp_q[0].due == cycle - 1);
        check_valid(res, expect_valid);
        if (expect_valid) begin
            check_data(res, exp_q[0].data);
            void'(exp_q.pop_front());
        end
    end

    initial begin
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: results did not arrive within %0d cycles", wd_cycles);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        div_req_t    r;
        logic [31:0] bits;
        rstn     = 1'b0;
        in_valid = 1'b0;
        req      = '0;
        check_table();
        repeat (reset_cycles) @(posedge clk);
        rstn <= 1'b1;
        repeat (idle_cycles) @(posedge clk);

        for (int i = 0; i < num_dir; i++) begin
            @(posedge clk);
            send_req(dir_tab[i].req, dir_tab[i].exp);
        end

        for (int i = 0; i < num_rand; i++) begin
            take_random(32, bits);
            r.dividend = bits;
            take_random(32, bits);
            r.divisor = bits;
            take_random(2, bits);
            if (bits[1:0] == 2'd0) begin
                r.divisor = r.divisor >> 24;   // small divisor
            end else if (bits[1:0] == 2'd1) begin
                r.divisor = r.divisor & 32'h0000_000f;   // zero now and then
            end
            take_random(1, bits);
            r.signed_op = bits[0];
            take_random(1, bits);
            r.rem_sel = bits[0];
            @(posedge clk);
            send_req(r, ref_div(r));
        end

        @(posedge clk);
        in_valid <= 1'b0;
        req      <= '0;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (drain_cycles) @(posedge clk);   // catch stray strobes

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
